// File: logic/hazardPkg.sv
`default_nettype none

package hazardPkg;

    // register index, matches the core's register address width
    typedef logic [6:0] regIdx_t;

    // operand source for the branch comparator and the ALU
    typedef logic [1:0] fwdSel_t;

    localparam fwdSel_t fwdNone  = 2'b00; // register file value
    localparam fwdSel_t fwdFromW = 2'b01; // writeback result
    localparam fwdSel_t fwdFromM = 2'b10; // memory-stage ALU result

    // stall bits {F, D, E, M, W}, fetch in the msb
    typedef logic [4:0] stallMask_t;

    // flush bits {D, E, M, W}, decode in the msb
    typedef logic [3:0] flushMask_t;

    // hazard FSM states
    typedef enum logic [3:0] {
        run           = 4'b0000,
        exception     = 4'b0001,
        loadUseBranch = 4'b0100,
        loadUseExec   = 4'b0101,
        aluWait       = 4'b1000,
        mulDivDrain   = 4'b1001,
        fetchWait     = 4'b1100,
        memWait       = 4'b1101,
        excMemWait    = 4'b1110
    } hazState_t;

endpackage

`default_nettype wire

// File: logic/forwardSelect.sv
`timescale 1ns/1ps
`default_nettype none

// Operand forwarding for the decode-stage branch comparator and the execute-stage ALU.
// Both stages pick from the same two producers: the memory-stage ALU result and the
// writeback result. Load data in memory is never forwarded.
module forwardSelect #(
    parameter int RegAddrWidth = 7
) (
    input  wire logic             rst,
    input  wire hazardPkg::regIdx_t rsD,
    input  wire hazardPkg::regIdx_t rtD,
    input  wire hazardPkg::regIdx_t rsE,
    input  wire hazardPkg::regIdx_t rtE,
    input  wire hazardPkg::regIdx_t writeRegM,
    input  wire hazardPkg::regIdx_t writeRegW,
    input  wire logic             regWriteM,
    input  wire logic             regWriteW,
    input  wire logic             memToRegM,
    output hazardPkg::fwdSel_t    fwdAD,
    output hazardPkg::fwdSel_t    fwdBD,
    output hazardPkg::fwdSel_t    fwdAE,
    output hazardPkg::fwdSel_t    fwdBE
);

    // match-and-priority for one operand, memory stage first
    function automatic hazardPkg::fwdSel_t pickSource(
        input logic [RegAddrWidth-1:0] src,
        input logic [RegAddrWidth-1:0] dstM,
        input logic [RegAddrWidth-1:0] dstW,
        input logic                    wrM,
        input logic                    wrW,
        input logic                    loadM
    );
        hazardPkg::fwdSel_t sel;
        sel = hazardPkg::fwdNone;
        if (src == '0) begin
            sel = hazardPkg::fwdNone; // r0 is hardwired
        end else if (wrM && !loadM && dstM == src) begin
            sel = hazardPkg::fwdFromM;
        end else if (wrW && dstW == src) begin
            sel = hazardPkg::fwdFromW;
        end
        return sel;
    endfunction

    always_comb begin
        if (rst) begin
            fwdAD = hazardPkg::fwdNone;
            fwdBD = hazardPkg::fwdNone;
            fwdAE = hazardPkg::fwdNone;
            fwdBE = hazardPkg::fwdNone;
        end else begin
            fwdAD = pickSource(rsD, writeRegM, writeRegW, regWriteM, regWriteW, memToRegM);
            fwdBD = pickSource(rtD, writeRegM, writeRegW, regWriteM, regWriteW, memToRegM);
            fwdAE = pickSource(rsE, writeRegM, writeRegW, regWriteM, regWriteW, memToRegM);
            fwdBE = pickSource(rtE, writeRegM, writeRegW, regWriteM, regWriteW, memToRegM);
        end
    end

endmodule

`default_nettype wire

// File: logic/mulDivTimer.sv
`timescale 1ns/1ps
`default_nettype none

// Drain window after a multiply/divide result is ready.
// Busy for exactly MulDivCycles clocks following the start pulse.
module mulDivTimer #(
    parameter int MulDivCycles = 2
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic drainStart,
    output logic      drainBusy
);

    localparam int CountWidth = (MulDivCycles < 1) ? 1 : $clog2(MulDivCycles + 1);

    logic [CountWidth-1:0] count; // cycles left in the window

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (drainStart) begin
            count <= CountWidth'(MulDivCycles); // restart on every pulse
        end else if (count != '0) begin
            count <= count - CountWidth'(1);
        end
    end

    assign drainBusy = (count != '0);

endmodule

`default_nettype wire

// File: logic/stallControl.sv
`timescale 1ns/1ps
`default_nettype none

// Hazard FSM. The next state is chosen by a fixed priority, and the stall/flush
// masks are decoded from the next state so they follow the inputs in the same cycle.
module stallControl (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               exceptionClean,
    input  wire logic               exceptionStall,
    input  wire logic               ifStall,
    input  wire logic               memStall,
    input  wire logic               isBranchD,
    input  wire logic               memReadE,
    input  wire logic               memReadM,
    input  wire logic               regWriteE,
    input  wire logic               regWriteM,
    input  wire logic               aluStall,
    input  wire logic               aluDone,
    input  wire logic               drainBusy,
    input  wire hazardPkg::regIdx_t rsD,
    input  wire hazardPkg::regIdx_t rtD,
    input  wire hazardPkg::regIdx_t writeRegE,
    input  wire hazardPkg::regIdx_t writeRegM,
    output logic                    drainStart,
    output hazardPkg::stallMask_t   stallMask,
    output hazardPkg::flushMask_t   flushMask
);

    hazardPkg::hazState_t state;
    hazardPkg::hazState_t nextState;

    logic anyException;
    logic branchLoadUse;
    logic execLoadUse;

    // true when dst feeds a nonzero decode operand
    function automatic logic feedsDecode(
        input hazardPkg::regIdx_t dst,
        input hazardPkg::regIdx_t srcA,
        input hazardPkg::regIdx_t srcB
    );
        return ((dst == srcA) && (srcA != '0)) || ((dst == srcB) && (srcB != '0));
    endfunction

    assign anyException  = exceptionClean || exceptionStall;
    assign branchLoadUse = isBranchD && memReadM && regWriteM
                           && feedsDecode(writeRegM, rsD, rtD); // load two ahead of a branch
    assign execLoadUse   = memReadE && regWriteE
                           && feedsDecode(writeRegE, rsD, rtD); // load right ahead

    always_comb begin
        if (rst) begin
            nextState = hazardPkg::run;
        end else if (anyException && (ifStall || memStall)) begin
            nextState = hazardPkg::excMemWait;
        end else if (anyException) begin
            nextState = hazardPkg::exception;
        end else if (memStall) begin
            nextState = hazardPkg::memWait;
        end else if (branchLoadUse) begin
            nextState = hazardPkg::loadUseBranch;
        end else if (execLoadUse) begin
            nextState = hazardPkg::loadUseExec;
        end else if (aluStall && !aluDone) begin
            nextState = hazardPkg::aluWait;
        end else if (drainBusy) begin
            nextState = hazardPkg::mulDivDrain; // timer runs on even if preempted
        end else if (ifStall) begin
            nextState = hazardPkg::fetchWait;
        end else begin
            nextState = hazardPkg::run;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= hazardPkg::run;
        end else begin
            state <= nextState;
        end
    end

    // one pulse as the ALU finishes
    assign drainStart = (state == hazardPkg::aluWait) && aluDone;

    always_comb begin
        case (nextState)
            hazardPkg::run: begin
                stallMask = 5'b00000;
                flushMask = 4'b0000;
            end
            hazardPkg::exception: begin
                stallMask = 5'b11111; // freeze and squash everything
                flushMask = 4'b1111;
            end
            hazardPkg::excMemWait: begin
                stallMask = 5'b11111;
                flushMask = 4'b1110; // writeback kept for the pending access
            end
            hazardPkg::memWait: begin
                stallMask = 5'b11110;
                flushMask = 4'b0001; // bubble into writeback
            end
            hazardPkg::loadUseBranch: begin
                stallMask = 5'b11110;
                flushMask = 4'b0010;
            end
            hazardPkg::loadUseExec: begin
                stallMask = 5'b11000;
                flushMask = 4'b0100; // bubble into execute
            end
            hazardPkg::aluWait: begin
                stallMask = 5'b11100;
                flushMask = 4'b0010;
            end
            hazardPkg::mulDivDrain: begin
                stallMask = 5'b11000;
                flushMask = 4'b0100;
            end
            hazardPkg::fetchWait: begin
                stallMask = 5'b11000;
                flushMask = 4'b0100;
            end
            default: begin
                stallMask = 5'b00000;
                flushMask = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit #(
    parameter int MulDivCycles = 2
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               exceptionClean,
    input  wire logic               exceptionStall,
    input  wire logic               ifStall,
    input  wire logic               memStall,
    input  wire logic               isBranchD,
    input  wire logic               memReadE,
    input  wire logic               memReadM,
    input  wire logic               regWriteE,
    input  wire logic               regWriteM,
    input  wire logic               regWriteW,
    input  wire logic               memToRegM,
    input  wire logic               aluStall,
    input  wire logic               aluDone,
    input  wire hazardPkg::regIdx_t rsD,
    input  wire hazardPkg::regIdx_t rtD,
    input  wire hazardPkg::regIdx_t rsE,
    input  wire hazardPkg::regIdx_t rtE,
    input  wire hazardPkg::regIdx_t writeRegE,
    input  wire hazardPkg::regIdx_t writeRegM,
    input  wire hazardPkg::regIdx_t writeRegW,
    output hazardPkg::fwdSel_t      fwdAD,
    output hazardPkg::fwdSel_t      fwdBD,
    output hazardPkg::fwdSel_t      fwdAE,
    output hazardPkg::fwdSel_t      fwdBE,
    output hazardPkg::stallMask_t   stallMask,
    output hazardPkg::flushMask_t   flushMask
);

    logic drainStart; // aluWait -> drain handoff
    logic drainBusy;

    forwardSelect #(
        .RegAddrWidth($bits(hazardPkg::regIdx_t))
    ) fwd (
        .rst       (rst),
        .rsD       (rsD),
        .rtD       (rtD),
        .rsE       (rsE),
        .rtE       (rtE),
        .writeRegM (writeRegM),
        .writeRegW (writeRegW),
        .regWriteM (regWriteM),
        .regWriteW (regWriteW),
        .memToRegM (memToRegM),
        .fwdAD     (fwdAD),
        .fwdBD     (fwdBD),
        .fwdAE     (fwdAE),
        .fwdBE     (fwdBE)
    );

    stallControl ctrl (
        .clk            (clk),
        .rst            (rst),
        .exceptionClean (exceptionClean),
        .exceptionStall (exceptionStall),
        .ifStall        (ifStall),
        .memStall       (memStall),
        .isBranchD      (isBranchD),
        .memReadE       (memReadE),
        .memReadM       (memReadM),
        .regWriteE      (regWriteE),
        .regWriteM      (regWriteM),
        .aluStall       (aluStall),
        .aluDone        (aluDone),
        .drainBusy      (drainBusy),
        .rsD            (rsD),
        .rtD            (rtD),
        .writeRegE      (writeRegE),
        .writeRegM      (writeRegM),
        .drainStart     (drainStart),
        .stallMask      (stallMask),
        .flushMask      (flushMask)
    );

    mulDivTimer #(
        .MulDivCycles(MulDivCycles)
    ) drain (
        .clk        (clk),
        .rst        (rst),
        .drainStart (drainStart),
        .drainBusy  (drainBusy)
    );

endmodule

`default_nettype wire

// File: include/hazardModel.svh
`ifndef HAZARD_MODEL_SVH
`define HAZARD_MODEL_SVH

hazardPkg::hazState_t modelState; // mirror of the FSM register
int modelCount;                   // drain cycles still to run

// expected source for one operand, memory-stage ALU result first
function automatic hazardPkg::fwdSel_t expectFwd(
    input hazardPkg::regIdx_t src,
    input hazardPkg::regIdx_t dstM,
    input hazardPkg::regIdx_t dstW,
    input logic               wrM,
    input logic               wrW,
    input logic               loadM,
    input logic               inReset
);
    hazardPkg::fwdSel_t sel;
    sel = hazardPkg::fwdNone;
    if (!inReset && src != 7'd0) begin
        if (wrM && !loadM && dstM == src) begin
            sel = hazardPkg::fwdFromM;
        end else if (wrW && dstW == src) begin
            sel = hazardPkg::fwdFromW;
        end
    end
    return sel;
endfunction

// a nonzero destination read by one of the decode operands
function automatic logic readInDecode(input hazardPkg::regIdx_t dst);
    return (dst != 7'd0) && (dst == rsD || dst == rtD);
endfunction

// priority list, reads the testbench inputs and the model state
function automatic hazardPkg::hazState_t expectNext();
    hazardPkg::hazState_t n;
    logic exc;
    exc = exceptionClean | exceptionStall;
    if (rst) begin
        n = hazardPkg::run;
    end else if (exc && (ifStall || memStall)) begin
        n = hazardPkg::excMemWait;
    end else if (exc) begin
        n = hazardPkg::exception;
    end else if (memStall) begin
        n = hazardPkg::memWait;
    end else if (isBranchD && memReadM && regWriteM && readInDecode(writeRegM)) begin
        n = hazardPkg::loadUseBranch;
    end else if (memReadE && regWriteE && readInDecode(writeRegE)) begin
        n = hazardPkg::loadUseExec;
    end else if (aluStall && !aluDone) begin
        n = hazardPkg::aluWait;
    end else if (modelCount != 0) begin
        n = hazardPkg::mulDivDrain;
    end else if (ifStall) begin
        n = hazardPkg::fetchWait;
    end else begin
        n = hazardPkg::run;
    end
    return n;
endfunction

function automatic hazardPkg::stallMask_t expectStall(input hazardPkg::hazState_t s);
    case (s)
        hazardPkg::exception, hazardPkg::excMemWait:  return 5'b11111;
        hazardPkg::memWait, hazardPkg::loadUseBranch: return 5'b11110;
        hazardPkg::aluWait:                           return 5'b11100; // F, D, E
        hazardPkg::loadUseExec, hazardPkg::mulDivDrain,
        hazardPkg::fetchWait:                         return 5'b11000;
        default:                                      return 5'b00000;
    endcase
endfunction

function automatic hazardPkg::flushMask_t expectFlush(input hazardPkg::hazState_t s);
    case (s)
        hazardPkg::exception:                         return 4'b1111;
        hazardPkg::excMemWait:                        return 4'b1110;
        hazardPkg::memWait:                           return 4'b0001; // W only
        hazardPkg::loadUseBranch, hazardPkg::aluWait: return 4'b0010;
        hazardPkg::loadUseExec, hazardPkg::mulDivDrain,
        hazardPkg::fetchWait:                         return 4'b0100;
        default:                                      return 4'b0000;
    endcase
endfunction

// advance state and drain counter as on a rising clk
task automatic stepModel();
    hazardPkg::hazState_t n;
    logic start;
    start = (modelState == hazardPkg::aluWait) && aluDone;
    n = expectNext(); // uses the count before this edge
    if (rst) begin
        modelCount = 0;
        modelState = hazardPkg::run;
    end else begin
        if (start) begin
            modelCount = MulDivCycles;
        end else if (modelCount != 0) begin
            modelCount = modelCount - 1;
        end
        modelState = n;
    end
endtask

`endif

// File: tb/hazardUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnitTb;

    localparam int MulDivCycles = 3;
    localparam int ResetCycles  = 16;
    localparam int NumCycles    = 4000;

    logic clk;
    logic rst;
    logic exceptionClean;
    logic exceptionStall;
    logic ifStall;
    logic memStall;
    logic isBranchD;
    logic memReadE;
    logic memReadM;
    logic regWriteE;
    logic regWriteM;
    logic regWriteW;
    logic memToRegM;
    logic aluStall;
    logic aluDone;
    hazardPkg::regIdx_t rsD;
    hazardPkg::regIdx_t rtD;
    hazardPkg::regIdx_t rsE;
    hazardPkg::regIdx_t rtE;
    hazardPkg::regIdx_t writeRegE;
    hazardPkg::regIdx_t writeRegM;
    hazardPkg::regIdx_t writeRegW;
    hazardPkg::fwdSel_t fwdAD;
    hazardPkg::fwdSel_t fwdBD;
    hazardPkg::fwdSel_t fwdAE;
    hazardPkg::fwdSel_t fwdBE;
    hazardPkg::stallMask_t stallMask;
    hazardPkg::flushMask_t flushMask;

    logic [31:0] lfsrState;

    `include "hazardModel.svh"

    hazardUnit #(
        .MulDivCycles(MulDivCycles)
    ) uut (
        .clk(clk), .rst(rst),
        .exceptionClean(exceptionClean), .exceptionStall(exceptionStall),
        .ifStall(ifStall), .memStall(memStall), .isBranchD(isBranchD),
        .memReadE(memReadE), .memReadM(memReadM),
        .regWriteE(regWriteE), .regWriteM(regWriteM), .regWriteW(regWriteW),
        .memToRegM(memToRegM), .aluStall(aluStall), .aluDone(aluDone),
        .rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
        .writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
        .fwdAD(fwdAD), .fwdBD(fwdBD), .fwdAE(fwdAE), .fwdBE(fwdBE),
        .stallMask(stallMask), .flushMask(flushMask)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #((ResetCycles + NumCycles) * 20 + 400); // all cycles plus a margin
        $display("watchdog expired, the stimulus loop never reached its end");
        $display("sim failed");
        $fatal(1, "timeout");
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic rareFlag(input int n);
        logic r;
        r = 1'b1;
        for (int i = 0; i < n; i++) begin
            r = r & lfsrBit(); // every bit is drawn
        end
        return r;
    endfunction

    // small pool so indices collide often
    function automatic hazardPkg::regIdx_t pickReg();
        logic [1:0] k;
        k = {lfsrBit(), lfsrBit()};
        case (k)
            2'd0:    return 7'd0;
            2'd1:    return 7'd3;
            2'd2:    return 7'd17;
            default: return 7'd127;
        endcase
    endfunction

    task automatic driveInputs(input logic quiet);
        rsD = pickReg();
        rtD = pickReg();
        rsE = pickReg();
        rtE = pickReg();
        writeRegE = pickReg();
        writeRegM = pickReg();
        writeRegW = pickReg();
        exceptionClean = rareFlag(5);
        exceptionStall = rareFlag(5);
        ifStall = rareFlag(3);
        memStall = rareFlag(4);
        isBranchD = rareFlag(2);
        memReadE = rareFlag(2);
        memReadM = rareFlag(2);
        regWriteE = lfsrBit();
        regWriteM = lfsrBit();
        regWriteW = lfsrBit();
        memToRegM = lfsrBit();
        aluStall = rareFlag(2);
        aluDone = lfsrBit();
        if (quiet) begin // no hazard, no writer
            {exceptionClean, exceptionStall, ifStall, memStall, isBranchD} = '0;
            {memReadE, memReadM, regWriteE, regWriteM, regWriteW} = '0;
            {memToRegM, aluStall, aluDone} = '0;
        end
    endtask

    task automatic checkFwd(input string name, input hazardPkg::fwdSel_t got,
                            input hazardPkg::fwdSel_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("sim failed");
            $fatal(1, "forwarding select mismatch");
        end
    endtask

    task automatic checkStall(input hazardPkg::stallMask_t got,
                              input hazardPkg::stallMask_t exp);
        if (got !== exp) begin
            $display("error at %0t: stallMask is %b, expected %b", $time, got, exp);
            $display("sim failed");
            $fatal(1, "stall mask mismatch");
        end
    endtask

    task automatic checkFlush(input hazardPkg::flushMask_t got,
                              input hazardPkg::flushMask_t exp);
        if (got !== exp) begin
            $display("error at %0t: flushMask is %b, expected %b", $time, got, exp);
            $display("sim failed");
            $fatal(1, "flush mask mismatch");
        end
    endtask

    task automatic checkAll();
        hazardPkg::hazState_t n;
        n = expectNext();
        checkFwd("fwdAD", fwdAD,
                 expectFwd(rsD, writeRegM, writeRegW, regWriteM, regWriteW, memToRegM, rst));
        checkFwd("fwdBD", fwdBD,
                 expectFwd(rtD, writeRegM, writeRegW, regWriteM, regWriteW, memToRegM, rst));
        checkFwd("fwdAE", fwdAE,
                 expectFwd(rsE, writeRegM, writeRegW, regWriteM, regWriteW, memToRegM, rst));
        checkFwd("fwdBE", fwdBE,
                 expectFwd(rtE, writeRegM, writeRegW, regWriteM, regWriteW, memToRegM, rst));
        checkStall(stallMask, expectStall(n));
        checkFlush(flushMask, expectFlush(n));
    endtask

    initial begin
        lfsrState = 32'hd433;
        modelState = hazardPkg::run;
        modelCount = 0;
        rst = 1'b1;
        {exceptionClean, exceptionStall, ifStall, memStall, isBranchD} = '0;
        {memReadE, memReadM, regWriteE, regWriteM, regWriteW} = '0;
        {memToRegM, aluStall, aluDone} = '0;
        {rsD, rtD, rsE, rtE} = '0;
        {writeRegE, writeRegM, writeRegW} = '0;
        for (int cycle = 0; cycle < ResetCycles + NumCycles; cycle++) begin
            @(negedge clk);
            rst = (cycle < ResetCycles - 1); // the edge at 10 ns is the first reset cycle
            driveInputs(cycle == ResetCycles - 1); // first cycle out of reset is quiet
            #5;
            checkAll();
            @(posedge clk);
            stepModel();
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hazardUnit.f
+incdir+include
logic/hazardPkg.sv
logic/forwardSelect.sv
logic/mulDivTimer.sv
logic/stallControl.sv
logic/hazardUnit.sv
tb/hazardUnitTb.sv

// File: Makefile
# sources come from the file list, plus the included model
SRCS = $(shell grep -v '^+' hazardUnit.f) include/hazardModel.svh

.PHONY: all run clean

all: run

obj_dir/VhazardUnitTb: hazardUnit.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps --top-module hazardUnitTb \
		-f hazardUnit.f

# the log decides pass or fail
run: obj_dir/VhazardUnitTb
	./obj_dir/VhazardUnitTb > sim.log 2>&1; cat sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
